/* branch_unit.f */
+incdir+source
+incdir+sim
source/branch_pkg.sv
source/branch_decode.sv
source/branch_execute.sv
source/branch_result.sv
source/branch_unit.sv
sim/tb_branch_unit.sv

/* Makefile */
VERILATOR  ?= verilator
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only -Wall --timing --assert
TOP        = tb_branch_unit
FILELIST   = branch_unit.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) source/*.sv source/*.svh sim/*.sv sim/*.svh
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/branch_model.svh */
`ifndef BRANCH_MODEL_SVH
`define BRANCH_MODEL_SVH

`include "branch_params.svh"

// Expected result from the instruction set rules
function automatic br_res_t expect_res(input br_req_t rq);
	logic [`BR_W-1:0] w;
	logic [`BR_W-1:0] rel;
	logic             take;
	br_res_t          r;
	w    = rq.instr;
	r    = '0;
	rel  = '0;
	take = 1'b0;
	case (w[15:11])
		`OP_B: begin
			take = 1'b1;
			rel  = {{(`BR_W-11){w[10]}}, w[10:0]};
		end
		`OP_BEQZ, `OP_BNEZ: begin
			take = (w[15:11] == `OP_BEQZ) ? (rq.op1 == '0) : (rq.op1 != '0);
			rel  = {{(`BR_W-8){w[7]}}, w[7:0]};
		end
		`OP_T8: begin
			if (w[10:8] == `T8_BTEQZ) begin
				take = (rq.op1 == '0);
			end else if (w[10:8] == `T8_BTNEZ) begin
				take = (rq.op1 != '0);
			end
			rel = {{(`BR_W-8){w[7]}}, w[7:0]};
		end
		`OP_JR: begin
			if (w[7:0] == `FN_JR || w[10:0] == `FN_JRRA) begin
				r.set_pc   = 1'b1;
				r.pc_value = rq.op1;
			end else if (w[7:0] == `FN_JALR) begin
				r.set_pc   = 1'b1;
				r.pc_value = rq.op1;
				r.write_ra = 1'b1;
				r.ra_value = rq.pc + `BR_W'(1); // Link past the jump
			end
		end
		default: begin
			r = '0;
		end
	endcase
	if (take) begin
		r.set_pc   = 1'b1;
		r.pc_value = rq.pc + rel + `BR_W'(1);
	end
	return r;
endfunction

task automatic check_res(input br_res_t got, input br_res_t exp, input string what);
	if (got.set_pc !== exp.set_pc) begin
		$display("ERROR %0t %s.set_pc got %0h expected %0h", $time, what, got.set_pc,
			exp.set_pc);
		value_errors++;
	end
	if (got.pc_value !== exp.pc_value) begin
		$display("ERROR %0t %s.pc_value got %0h expected %0h", $time, what, got.pc_value,
			exp.pc_value);
		value_errors++;
	end
	if (got.write_ra !== exp.write_ra) begin
		$display("ERROR %0t %s.write_ra got %0h expected %0h", $time, what, got.write_ra,
			exp.write_ra);
		value_errors++;
	end
	if (got.ra_value !== exp.ra_value) begin
		$display("ERROR %0t %s.ra_value got %0h expected %0h", $time, what, got.ra_value,
			exp.ra_value);
		value_errors++;
	end
endtask

task automatic check_latency(input int got, input int exp, input string what);
	if (got != exp) begin
		$display("ERROR %0t %s got %0d expected %0d", $time, what, got, exp);
		latency_errors++;
	end
endtask

`endif

/* sim/tb_branch_unit.sv */
`timescale 1ns/1ps
`include "branch_params.svh"

module tb_branch_unit import branch_pkg::*; ();

	localparam int NUM_RANDOM  = 400;
	localparam int ACK_TIMEOUT = 20;

	logic    clk;
	logic    arst_n;
	logic    req;
	br_req_t req_data;
	logic    ack;
	br_res_t res;

	int value_errors    = 0;
	int latency_errors  = 0;
	int protocol_errors = 0;
	int timeout_errors  = 0;

	`include "branch_model.svh"

	branch_unit i_branch_unit (
		.clk      (clk),
		.arst_n   (arst_n),
		.req      (req),
		.req_data (req_data),
		.ack      (ack),
		.res      (res)
	);

	function automatic br_req_t make_req(input logic [`BR_W-1:0] pc,
		input logic [`BR_W-1:0] instr, input logic [`BR_W-1:0] op1);
		br_req_t rq;
		rq.pc    = pc;
		rq.instr = instr;
		rq.op1   = op1;
		return rq;
	endfunction

	// Mostly valid encodings plus near misses and noise
	function automatic logic [`BR_W-1:0] random_instr();
		int unsigned pick;
		logic [2:0]  rx;
		logic [7:0]  imm;
		logic [7:0]  flip;
		pick = $urandom_range(0, 9);
		rx   = 3'($urandom);
		imm  = 8'($urandom);
		flip = 8'd1 << 3'($urandom);
		case (pick)
			0: return {`OP_B, 11'($urandom)};
			1: return {`OP_BEQZ, rx, imm};
			2: return {`OP_BNEZ, rx, imm};
			3: return {`OP_T8, `T8_BTEQZ, imm};
			4: return {`OP_T8, `T8_BTNEZ, imm};
			5: return {`OP_JR, rx, `FN_JR};
			6: return {`OP_JR, rx, `FN_JALR};
			7: return {`OP_JR, `FN_JRRA};
			8: begin
				if ($urandom_range(0, 1) == 0) begin
					return {`OP_JR, rx, imm[0] ? (`FN_JR ^ flip) : (`FN_JALR ^ flip)};
				end else begin
					return {`OP_T8, 3'($urandom_range(2, 7)), imm}; // Unused sub-opcode
				end
			end
			default: return `BR_W'($urandom);
		endcase
	endfunction

	function automatic br_req_t random_req();
		logic [`BR_W-1:0] op1;
		op1 = ($urandom_range(0, 3) == 0) ? '0 : `BR_W'($urandom);
		return make_req(`BR_W'($urandom), random_instr(), op1);
	endfunction

	// One full four-phase transaction
	task automatic run_request(input br_req_t rq);
		br_res_t exp;
		int      cycles;
		int      gap;
		int      hold;
		if (timeout_errors != 0) begin
			return;
		end
		exp  = expect_res(rq);
		gap  = $urandom_range(0, 3);
		hold = $urandom_range(0, 6);
		repeat (gap) @(posedge clk);
		@(posedge clk);
		req      <= 1'b1;
		req_data <= rq;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
		end while (ack !== 1'b1 && cycles < ACK_TIMEOUT);
		if (ack !== 1'b1) begin
			$display("Timeout: ack did not rise within %0d cycles of req", ACK_TIMEOUT);
			timeout_errors++;
			return;
		end
		check_latency(cycles, 3, "ack rise latency");
		check_res(res, exp, "res");
		repeat (hold) begin // Back-pressure
			@(posedge clk);
			req_data <= random_req(); // A new word must not start a second result
			@(negedge clk);
			if (ack !== 1'b1) begin
				$display("ERROR %0t ack got %0b expected 1", $time, ack);
				protocol_errors++;
			end
			check_res(res, exp, "res held");
		end
		@(posedge clk);
		req      <= 1'b0;
		req_data <= random_req(); // Must be ignored while req is low
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
		end while (ack !== 1'b0 && cycles < ACK_TIMEOUT);
		if (ack !== 1'b0) begin
			$display("Timeout: ack did not fall within %0d cycles of req", ACK_TIMEOUT);
			timeout_errors++;
			return;
		end
		check_latency(cycles, 1, "ack fall latency");
		check_res(res, '0, "res after ack fall");
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		void'($urandom(11));
		arst_n   = 1'b0;
		req      = 1'b0;
		req_data = '0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		if (ack !== 1'b0) begin
			$display("ERROR %0t ack got %0b expected 0", $time, ack);
			protocol_errors++;
		end
		check_res(res, '0, "res after reset");

		run_request(make_req(16'hFFFE, {`OP_B, 11'd5}, 16'h1234)); // Wraps past zero
		run_request(make_req(16'h0010, {`OP_B, 11'h7F0}, 16'h0000));
		run_request(make_req(16'h8000, {`OP_BEQZ, 3'd2, 8'h80}, 16'h0000));
		run_request(make_req(16'h8000, {`OP_BNEZ, 3'd2, 8'h80}, 16'h0000));
		run_request(make_req(16'h0001, {`OP_T8, `T8_BTNEZ, 8'hFE}, 16'h0040));
		run_request(make_req(16'hFFFF, {`OP_JR, 3'd1, `FN_JALR}, 16'hABCD));
		run_request(make_req(16'h0100, {`OP_JR, `FN_JRRA}, 16'h2468));
		run_request(make_req(16'h0100, {`OP_T8, 3'd5, 8'h10}, 16'h0000));
		for (int n = 0; n < NUM_RANDOM; n++) begin
			run_request(random_req());
		end

		$display("Error counts: value %0d, latency %0d, protocol %0d, timeout %0d",
			value_errors, latency_errors, protocol_errors, timeout_errors);
		if (value_errors + latency_errors + protocol_errors + timeout_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* source/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import branch_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    req,
	input  br_req_t req_data,
	output logic    ack,
	output br_res_t res
);

	br_dec_t dec;
	logic    dec_valid;
	br_res_t ex_res;
	logic    ex_valid;

	// Classify and sign-extend
	branch_decode i_branch_decode (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.req_data  (req_data),
		.dec       (dec),
		.dec_valid (dec_valid)
	);

	// Condition and target
	branch_execute i_branch_execute (
		.clk       (clk),
		.arst_n    (arst_n),
		.dec       (dec),
		.dec_valid (dec_valid),
		.ex_res    (ex_res),
		.ex_valid  (ex_valid)
	);

	// Holds res and drives ack
	branch_result i_branch_result (
		.clk      (clk),
		.arst_n   (arst_n),
		.ex_res   (ex_res),
		.ex_valid (ex_valid),
		.req      (req),
		.ack      (ack),
		.res      (res)
	);

endmodule

/* source/branch_result.sv */
`timescale 1ns/1ps

module branch_result import branch_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  br_res_t ex_res,
	input  logic    ex_valid,
	input  logic    req,
	output logic    ack,
	output br_res_t res
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack <= 1'b0;
			res <= '0;
		end else if (!req) begin
			ack <= 1'b0; // Phase 4 of the handshake
			res <= '0;
		end else if (ex_valid) begin
			ack <= 1'b1;
			res <= ex_res;
		end
	end

	// Requester must release req before ack may drop
	a_ack_hold: assert property (@(posedge clk) disable iff (!arst_n)
		ack && req |=> ack)
		else $error("ack fell while req was high");

	a_res_stable: assert property (@(posedge clk) disable iff (!arst_n)
		ack |=> !ack || $stable(res))
		else $error("res changed while ack was high");

	// A second result must not show up during back-pressure
	a_no_reload: assert property (@(posedge clk) disable iff (!arst_n)
		ack |-> !ex_valid)
		else $error("new result arrived while ack was high");

endmodule

/* source/branch_execute.sv */
`timescale 1ns/1ps
`include "branch_params.svh"

module branch_execute import branch_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  br_dec_t dec,
	input  logic    dec_valid,
	output br_res_t ex_res,
	output logic    ex_valid
);

	logic [`BR_W-1:0] target;
	logic [`BR_W-1:0] link;
	logic             op1_zero;
	br_res_t          res_c;

	assign target   = dec.pc + dec.offset + `BR_W'(1);
	assign link     = dec.pc + `BR_W'(1);
	assign op1_zero = (dec.op1 == '0);

	always_comb begin
		res_c = '0;
		case (dec.kind)
			K_B: begin
				res_c.set_pc   = 1'b1;
				res_c.pc_value = target;
			end
			K_BEQZ, K_BTEQZ: begin
				if (op1_zero) begin
					res_c.set_pc   = 1'b1;
					res_c.pc_value = target;
				end
			end
			K_BNEZ, K_BTNEZ: begin
				if (!op1_zero) begin
					res_c.set_pc   = 1'b1;
					res_c.pc_value = target;
				end
			end
			K_JR, K_JRRA: begin
				res_c.set_pc   = 1'b1;
				res_c.pc_value = dec.op1; // Register target
			end
			K_JALR: begin
				res_c.set_pc   = 1'b1;
				res_c.pc_value = dec.op1;
				res_c.write_ra = 1'b1;
				res_c.ra_value = link;
			end
			default: begin
				res_c = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= dec_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			ex_res <= res_c;
		end
	end

	a_ra_needs_jump: assert property (@(posedge clk) disable iff (!arst_n)
		ex_valid && ex_res.write_ra |-> ex_res.set_pc)
		else $error("write_ra without set_pc");

endmodule

/* source/branch_decode.sv */
`timescale 1ns/1ps
`include "branch_params.svh"

module branch_decode import branch_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    req,
	input  br_req_t req_data,
	output br_dec_t dec,
	output logic    dec_valid
);

	logic             seen;
	logic             capture;
	br_kind_e         kind_c;
	logic [`BR_W-1:0] offset_c;

	assign capture = req && !seen;

	always_comb begin
		kind_c   = K_NONE;
		offset_c = '0;
		case (req_data.instr.i11_f.op)
			`OP_B: begin
				kind_c   = K_B;
				offset_c = {{(`BR_W-11){req_data.instr.i11_f.offset[10]}},
					req_data.instr.i11_f.offset};
			end
			`OP_BEQZ: begin
				kind_c   = K_BEQZ;
				offset_c = {{(`BR_W-8){req_data.instr.ri8_f.imm[7]}},
					req_data.instr.ri8_f.imm};
			end
			`OP_BNEZ: begin
				kind_c   = K_BNEZ;
				offset_c = {{(`BR_W-8){req_data.instr.ri8_f.imm[7]}},
					req_data.instr.ri8_f.imm};
			end
			`OP_T8: begin
				if (req_data.instr.t8_f.sub == `T8_BTEQZ) begin
					kind_c = K_BTEQZ;
				end else if (req_data.instr.t8_f.sub == `T8_BTNEZ) begin
					kind_c = K_BTNEZ;
				end
				if (kind_c != K_NONE) begin // Other sub-opcodes keep a zero offset
					offset_c = {{(`BR_W-8){req_data.instr.t8_f.offset[7]}},
						req_data.instr.t8_f.offset};
				end
			end
			`OP_JR: begin
				if (req_data.instr.ri8_f.imm == `FN_JR) begin
					kind_c = K_JR;
				end else if (req_data.instr.ri8_f.imm == `FN_JALR) begin
					kind_c = K_JALR;
				end else if (req_data.instr.i11_f.offset == `FN_JRRA) begin
					kind_c = K_JRRA; // Whole low field must match
				end
			end
			default: begin
				kind_c   = K_NONE;
				offset_c = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			seen      <= 1'b0;
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= capture;
			if (!req) begin
				seen <= 1'b0; // Ready for the next phase
			end else if (capture) begin
				seen <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			dec.kind   <= kind_c;
			dec.offset <= offset_c;
			dec.pc     <= req_data.pc;
			dec.op1    <= req_data.op1;
		end
	end

	a_dec_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		dec_valid |=> !dec_valid)
		else $error("dec_valid held high for two cycles");

endmodule

/* source/branch_pkg.sv */
`include "branch_params.svh"

package branch_pkg;

	// I11 format, B
	typedef struct packed {
		logic [4:0]  op;
		logic [10:0] offset;
	} br_i11_t;

	// RI8 format, BEQZ, BNEZ and the JR group
	typedef struct packed {
		logic [4:0] op;
		logic [2:0] rx;
		logic [7:0] imm;
	} br_ri8_t;

	// T8 format, BTEQZ and BTNEZ
	typedef struct packed {
		logic [4:0] op;
		logic [2:0] sub;
		logic [7:0] offset;
	} br_t8_t;

	typedef union packed {
		br_i11_t i11_f;
		br_ri8_t ri8_f;
		br_t8_t  t8_f;
	} br_instr_u;

	typedef enum logic [3:0] {
		K_NONE,
		K_B,
		K_BEQZ,
		K_BNEZ,
		K_BTEQZ,
		K_BTNEZ,
		K_JR,
		K_JALR,
		K_JRRA
	} br_kind_e;

	typedef struct packed {
		logic [`BR_W-1:0] pc;
		br_instr_u        instr;
		logic [`BR_W-1:0] op1; // rx, T or RA depending on the instruction
	} br_req_t;

	typedef struct packed {
		br_kind_e         kind;
		logic [`BR_W-1:0] offset; // Already sign-extended
		logic [`BR_W-1:0] pc;
		logic [`BR_W-1:0] op1;
	} br_dec_t;

	typedef struct packed {
		logic             set_pc;
		logic [`BR_W-1:0] pc_value;
		logic             write_ra;
		logic [`BR_W-1:0] ra_value;
	} br_res_t;

endpackage

/* source/branch_params.svh */
`ifndef BRANCH_PARAMS_SVH
`define BRANCH_PARAMS_SVH

// Data path width, fixed by the instruction set
`define BR_W 16

// Major opcodes in bits 15:11
`define OP_B    5'b00010
`define OP_BEQZ 5'b00100
`define OP_BNEZ 5'b00101
`define OP_T8   5'b01100
`define OP_JR   5'b11101

// T8 sub-opcodes in bits 10:8
`define T8_BTEQZ 3'b000
`define T8_BTNEZ 3'b001

// Function fields under OP_JR
`define FN_JR   8'b00000000
`define FN_JALR 8'b11000000
`define FN_JRRA 11'b00000100000

`endif
